// ==== filelist.f ====
+incdir+.
branch_types_pkg.sv
branch_predictor.sv
pred_pipe.sv
branch_resolve.sv
fetch_pc.sv
branch_unit.sv
branch_unit_tb.sv

// ==== Bender.yml ====
package:
  name: branch_unit

export_include_dirs:
  - .

sources:
  - branch_types_pkg.sv
  - branch_predictor.sv
  - pred_pipe.sv
  - branch_resolve.sv
  - fetch_pc.sv
  - branch_unit.sv
  - target: test
    files:
      - branch_unit_tb.sv

// ==== branch_unit_tb.sv ====
// self-checking testbench for branch_unit that plays instruction memory and models the pc path

`include "branch_settings.svh"

module branch_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import branch_types_pkg::*;

    localparam int RUN_CYCLES   = 360;
    localparam int LIMIT_CYCLES = RUN_CYCLES + 40;          // 400 cycles for the watchdog
    localparam logic [`PC_WIDTH-1:0] LOOP_TARGET = 32'h10; // loop head
    localparam logic [`PC_WIDTH-1:0] BNE_PC      = 32'h18; // random skip over 0x1c
    localparam logic [`PC_WIDTH-1:0] LOOP_PC     = 32'h20; // beq back to head and bne target

    // one fetched instruction as the model sees it
    typedef struct packed {
        logic                 valid;
        logic [`PC_WIDTH-1:0] pc;
        branch_op_t           op;
        logic [`PC_WIDTH-1:0] target;
        logic                 taken;
        logic                 ptaken;
        logic [`PC_WIDTH-1:0] ptarget;
    } fetch_rec_t;

    logic                 CLK;
    logic                 nRST;
    logic                 stall;
    branch_op_t           op_fetch;
    logic [`PC_WIDTH-1:0] target_fetch;
    logic                 taken_fetch;
    logic [`PC_WIDTH-1:0] pc_fetch;
    logic                 pred_taken;
    logic [`PC_WIDTH-1:0] pred_target;
    logic                 redirect;
    logic [`PC_WIDTH-1:0] redirect_pc;
    logic                 retire_valid;
    logic [`PC_WIDTH-1:0] retire_pc;

    logic [19:0] lfsr; // stimulus source

    // reference model state
    pred_state_t          m_state [`BP_ENTRIES];
    logic [`PC_WIDTH-1:0] m_btb   [`BP_ENTRIES];
    fetch_rec_t           rec_q[$];  // front is youngest and back is memory stage
    fetch_rec_t           mem_rec;   // copy of the back entry
    logic [`PC_WIDTH-1:0] m_pc;      // expected pc_fetch
    logic [`PC_WIDTH-1:0] m_arch;    // next pc expected to retire
    int                   n_redirect;
    int                   n_loop_pred;
    int                   n_stall;

    logic                 exp_pred_taken;
    logic [`PC_WIDTH-1:0] exp_pred_target;
    logic                 exp_retire;
    logic                 exp_redirect;
    logic [`PC_WIDTH-1:0] exp_redirect_pc;

    branch_unit UUT (.*);

    always #2 CLK = ~CLK; // 4 ns period

    function automatic logic [19:0] lfsr_next(input logic [19:0] s);
        return {s[18:0], s[19] ^ s[16]}; // x^20 + x^17 + 1
    endfunction

    task automatic draw_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    function automatic logic [`BP_INDEX_HI-2:0] table_index(input logic [`PC_WIDTH-1:0] pc);
        return pc[`BP_INDEX_HI:2];
    endfunction

    function automatic logic predicts_taken(input pred_state_t s);
        return s inside {TAKEN_HARD, TAKEN_SOFT};
    endfunction

    // wrong guess steps one place round the ring and right guess goes hard in its direction
    function automatic pred_state_t trained(input pred_state_t s, input logic wrong);
        logic [1:0] v;
        v = wrong ? s + 2'd1 : {s[1], 1'b0};
        return pred_state_t'(v);
    endfunction

    function automatic logic [`PC_WIDTH-1:0] actual_next(input fetch_rec_t r);
        if (r.op != OP_NONE && r.taken)
            return r.target;
        return r.pc + `PC_WIDTH'd4;
    endfunction

    function automatic logic [`PC_WIDTH-1:0] guessed_next(input fetch_rec_t r);
        return r.ptaken ? r.ptarget : r.pc + `PC_WIDTH'd4;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // instruction memory for the current pc_fetch plus random stall
    task automatic drive_cycle();
        logic [2:0] s;
        logic       b;
        for (int i = 0; i < 3; i++) begin
            draw_bit(b);
            s[i] = b;
        end
        stall        = (s == 3'b111); // about one cycle in eight
        op_fetch     = OP_NONE;
        target_fetch = '0;
        taken_fetch  = 1'b0;
        if (pc_fetch == BNE_PC) begin
            op_fetch     = OP_BNE;
            target_fetch = LOOP_PC;
            draw_bit(b);
            taken_fetch  = b;          // coin flip outcome
        end else if (pc_fetch == LOOP_PC) begin
            op_fetch     = OP_BEQ;
            target_fetch = LOOP_TARGET;
            taken_fetch  = 1'b1;       // loop always closes
        end
    endtask

    always_comb begin
        exp_pred_taken  = predicts_taken(m_state[table_index(m_pc)])
                          && m_btb[table_index(m_pc)] != '0;
        exp_pred_target = exp_pred_taken ? m_btb[table_index(m_pc)] : '0;
        exp_retire      = mem_rec.valid && !stall;
        exp_redirect    = exp_retire && actual_next(mem_rec) != guessed_next(mem_rec);
        exp_redirect_pc = actual_next(mem_rec);
    end

    // model steps on each edge and looks up before training as in hardware
    always @(posedge CLK or negedge nRST) begin : model
        fetch_rec_t                fresh;
        logic                      redir;
        logic [`BP_INDEX_HI-2:0]   fi;
        logic [`BP_INDEX_HI-2:0]   ti;
        if (!nRST) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                m_state[i] = TAKEN_HARD;
                m_btb[i]   = '0;
            end
            rec_q.delete();
            for (int i = 0; i < `PIPE_DEPTH; i++)
                rec_q.push_back('0);
            mem_rec = '0;
            m_pc    = `RESET_PC;
            m_arch  = `RESET_PC;
        end else if (stall) begin
            n_stall++;
        end else begin
            fi            = table_index(m_pc);
            fresh.valid   = 1'b1;
            fresh.pc      = m_pc;
            fresh.op      = op_fetch;
            fresh.target  = target_fetch;
            fresh.taken   = taken_fetch;
            fresh.ptaken  = predicts_taken(m_state[fi]) && m_btb[fi] != '0;
            fresh.ptarget = fresh.ptaken ? m_btb[fi] : '0;
            redir = mem_rec.valid && actual_next(mem_rec) != guessed_next(mem_rec);
            if (mem_rec.valid) begin
                m_arch = actual_next(mem_rec); // architectural path moves on
                if (mem_rec.op != OP_NONE) begin
                    ti          = table_index(mem_rec.pc);
                    m_state[ti] = trained(m_state[ti], mem_rec.ptaken != mem_rec.taken);
                    m_btb[ti]   = mem_rec.target;
                end
            end
            if (fresh.pc == LOOP_PC && fresh.ptaken && !redir)
                n_loop_pred++;
            void'(rec_q.pop_back());
            rec_q.push_front(fresh);
            if (redir) begin
                foreach (rec_q[i])
                    rec_q[i].valid = 1'b0; // younger ones are wrong path
                n_redirect++;
                m_pc = actual_next(mem_rec);
            end else begin
                m_pc = fresh.ptaken ? fresh.ptarget : m_pc + `PC_WIDTH'd4;
            end
            mem_rec = rec_q[$];
        end
    end

    a_reset: assert property (@(posedge CLK)
        !nRST |-> pc_fetch == `RESET_PC && !redirect && !retire_valid)
        else abort_run($sformatf("mismatch at %0t: outputs not in reset state", $time));
    a_pc: assert property (@(posedge CLK) disable iff (!nRST) pc_fetch == m_pc)
        else abort_run($sformatf("mismatch at %0t: pc_fetch %h, model %h",
                                 $time, $sampled(pc_fetch), $sampled(m_pc)));
    a_pred: assert property (@(posedge CLK) disable iff (!nRST)
        pred_taken == exp_pred_taken && pred_target == exp_pred_target)
        else abort_run($sformatf("mismatch at %0t: prediction for pc %h",
                                 $time, $sampled(pc_fetch)));
    a_redirect: assert property (@(posedge CLK) disable iff (!nRST)
        redirect == exp_redirect && (!redirect || redirect_pc == exp_redirect_pc))
        else abort_run($sformatf("mismatch at %0t: redirect %b to %h, model %b to %h",
                                 $time, $sampled(redirect), $sampled(redirect_pc),
                                 $sampled(exp_redirect), $sampled(exp_redirect_pc)));
    a_retire: assert property (@(posedge CLK) disable iff (!nRST)
        retire_valid == exp_retire && (!retire_valid || retire_pc == m_arch))
        else abort_run($sformatf("mismatch at %0t: retire pc %h, architectural pc %h",
                                 $time, $sampled(retire_pc), $sampled(m_arch)));
    a_stall_quiet: assert property (@(posedge CLK) disable iff (!nRST)
        stall |-> !redirect && !retire_valid)
        else abort_run($sformatf("mismatch at %0t: strobe raised during stall", $time));
    a_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
        stall |=> pc_fetch == $past(m_pc))
        else abort_run($sformatf("mismatch at %0t: pc_fetch moved under stall", $time));
    a_follow: assert property (@(posedge CLK) disable iff (!nRST)
        exp_redirect |=> pc_fetch == $past(exp_redirect_pc))
        else abort_run($sformatf("mismatch at %0t: fetch did not follow redirect", $time));
    a_loop_jump: assert property (@(posedge CLK) disable iff (!nRST)
        m_pc == LOOP_PC && exp_pred_taken && !stall && !exp_redirect
        |=> pc_fetch == LOOP_TARGET)
        else abort_run($sformatf("mismatch at %0t: predicted loop branch not followed", $time));
    a_seq: assert property (@(posedge CLK) disable iff (!nRST)
        !stall && !exp_redirect && !exp_pred_taken |=> pc_fetch == $past(m_pc) + `PC_WIDTH'd4)
        else abort_run($sformatf("mismatch at %0t: sequential fetch did not add 4", $time));

    initial begin : watchdog
        #(LIMIT_CYCLES * 4 + 20);
        abort_run("watchdog expired before the test sequence finished");
    end

    initial begin : stimulus
        CLK          = 1'b0;
        nRST         = 1'b1;
        stall        = 1'b0;
        op_fetch     = OP_NONE;
        target_fetch = '0;
        taken_fetch  = 1'b0;
        lfsr         = 20'd98880;
        #0.5 nRST = 1'b0; // clean falling edge for the async reset
        repeat (2) @(posedge CLK);
        #0.5 nRST = 1'b1;
        for (int c = 0; c < RUN_CYCLES; c++) begin
            @(posedge CLK);
            #0.5;
            drive_cycle();
        end
        repeat (2) @(posedge CLK);
        #1;
        if (n_redirect > 0 && n_loop_pred > 0 && n_stall > 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("stimulus never reached a redirect, a predicted loop branch or a stall");
        end
    end

endmodule

// ==== branch_unit.sv ====
// top of the branch prediction front end, wires pc register, predictor, record pipe and resolver

`include "branch_settings.svh"

module branch_unit (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         stall,        // freezes the whole subsystem
    input  branch_types_pkg::branch_op_t op_fetch,     // decoded op at pc_fetch
    input  logic [`PC_WIDTH-1:0]         target_fetch, // resolved target at pc_fetch
    input  logic                         taken_fetch,  // resolved outcome at pc_fetch
    output logic [`PC_WIDTH-1:0]         pc_fetch,
    output logic                         pred_taken,
    output logic [`PC_WIDTH-1:0]         pred_target,
    output logic                         redirect,
    output logic [`PC_WIDTH-1:0]         redirect_pc,
    output logic                         retire_valid,
    output logic [`PC_WIDTH-1:0]         retire_pc
);

    import branch_types_pkg::*;

    // memory stage record
    logic                 mem_valid;
    logic [`PC_WIDTH-1:0] mem_pc;
    branch_op_t           mem_op;
    logic [`PC_WIDTH-1:0] mem_target;
    logic                 mem_taken;
    logic                 mem_pred_taken;
    logic [`PC_WIDTH-1:0] mem_pred_target;

    // training path back to the tables
    logic                 train;
    logic [`PC_WIDTH-1:0] train_pc;
    logic                 dir_wrong;
    logic [`PC_WIDTH-1:0] train_target;

    fetch_pc u_fetch_pc (
        .CLK, .nRST, .stall,
        .redirect, .redirect_pc,
        .pred_taken, .pred_target,
        .pc_fetch
    );

    branch_predictor u_predictor (
        .CLK, .nRST, .pc_fetch,
        .train, .train_pc, .dir_wrong, .train_target,
        .pred_taken, .pred_target
    );

    pred_pipe u_pipe (
        .CLK, .nRST, .stall,
        .flush (redirect), // younger records are wrong path
        .pc_fetch, .op_fetch, .target_fetch, .taken_fetch,
        .pred_taken, .pred_target,
        .mem_valid, .mem_pc, .mem_op, .mem_target, .mem_taken,
        .mem_pred_taken, .mem_pred_target
    );

    branch_resolve u_resolve (
        .stall,
        .mem_valid, .mem_pc, .mem_op, .mem_target, .mem_taken,
        .mem_pred_taken, .mem_pred_target,
        .redirect, .redirect_pc,
        .train, .train_pc, .dir_wrong, .train_target,
        .retire_valid, .retire_pc
    );

endmodule

// ==== fetch_pc.sv ====
// fetch program counter, picks redirect over predicted target over sequential pc each cycle

`include "branch_settings.svh"

module fetch_pc (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 stall,       // freeze pc
    input  logic                 redirect,    // memory stage correction
    input  logic [`PC_WIDTH-1:0] redirect_pc,
    input  logic                 pred_taken,  // prediction for current pc
    input  logic [`PC_WIDTH-1:0] pred_target,
    output logic [`PC_WIDTH-1:0] pc_fetch
);

    logic [`PC_WIDTH-1:0] pc_seq;  // fall through address
    logic [`PC_WIDTH-1:0] pc_next;

    assign pc_seq = pc_fetch + `PC_WIDTH'd4;

    // older instruction wins, redirect overrides any prediction
    always_comb begin
        if (redirect)
            pc_next = redirect_pc;
        else if (pred_taken)
            pc_next = pred_target;   // follow the btb
        else
            pc_next = pc_seq;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc_fetch <= `RESET_PC;
        end else if (!stall) begin
            pc_fetch <= pc_next; // one step per non-stalled edge
        end
    end

endmodule

// ==== branch_resolve.sv ====
// memory stage check of predicted against actual next pc, drives redirect, training and retire

`include "branch_settings.svh"

module branch_resolve (
    input  logic                         stall,
    input  logic                         mem_valid,
    input  logic [`PC_WIDTH-1:0]         mem_pc,
    input  branch_types_pkg::branch_op_t mem_op,
    input  logic [`PC_WIDTH-1:0]         mem_target,     // resolved branch address
    input  logic                         mem_taken,      // resolved outcome
    input  logic                         mem_pred_taken,
    input  logic [`PC_WIDTH-1:0]         mem_pred_target,
    output logic                         redirect,       // one cycle pulse
    output logic [`PC_WIDTH-1:0]         redirect_pc,
    output logic                         train,
    output logic [`PC_WIDTH-1:0]         train_pc,
    output logic                         dir_wrong,
    output logic [`PC_WIDTH-1:0]         train_target,
    output logic                         retire_valid,
    output logic [`PC_WIDTH-1:0]         retire_pc
);

    import branch_types_pkg::*;

    logic                 is_branch;
    logic                 actual_taken;
    logic                 active;      // record really leaves this cycle
    logic [`PC_WIDTH-1:0] pc_plus4;
    logic [`PC_WIDTH-1:0] actual_next;
    logic [`PC_WIDTH-1:0] pred_next;

    assign is_branch    = (mem_op == OP_BEQ) || (mem_op == OP_BNE);
    assign actual_taken = is_branch && mem_taken; // outcome ignored for non-branches
    assign active       = mem_valid && !stall;

    assign pc_plus4 = mem_pc + `PC_WIDTH'd4;

    // where execution really goes
    assign actual_next = actual_taken ? mem_target : pc_plus4;

    // where fetch went after this pc
    assign pred_next = mem_pred_taken ? mem_pred_target : pc_plus4;

    // covers wrong direction and right direction with a stale target
    assign redirect    = active && (actual_next != pred_next);
    assign redirect_pc = actual_next;

    // training only for real branches
    assign train        = active && is_branch;
    assign train_pc     = mem_pc;
    assign dir_wrong    = mem_pred_taken != actual_taken;
    assign train_target = mem_target;

    // redirecting record retires too, only younger ones are flushed
    assign retire_valid = active;
    assign retire_pc    = mem_pc;

endmodule

// ==== pred_pipe.sv ====
// shift chain carrying each fetched pc, its branch fields and its prediction to the memory stage

`include "branch_settings.svh"

module pred_pipe (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        stall,          // hold every stage
    input  logic                        flush,          // kill all in-flight records
    input  logic [`PC_WIDTH-1:0]        pc_fetch,
    input  branch_types_pkg::branch_op_t op_fetch,
    input  logic [`PC_WIDTH-1:0]        target_fetch,
    input  logic                        taken_fetch,
    input  logic                        pred_taken,
    input  logic [`PC_WIDTH-1:0]        pred_target,
    output logic                        mem_valid,
    output logic [`PC_WIDTH-1:0]        mem_pc,
    output branch_types_pkg::branch_op_t mem_op,
    output logic [`PC_WIDTH-1:0]        mem_target,
    output logic                        mem_taken,
    output logic                        mem_pred_taken,
    output logic [`PC_WIDTH-1:0]        mem_pred_target
);

    import branch_types_pkg::*;

    localparam int LAST = `PIPE_DEPTH - 1; // memory stage slot

    logic [`PIPE_DEPTH-1:0] stage_valid;   // bit 0 is the youngest

    logic [`PC_WIDTH-1:0] stage_pc          [`PIPE_DEPTH];
    branch_op_t           stage_op          [`PIPE_DEPTH];
    logic [`PC_WIDTH-1:0] stage_target      [`PIPE_DEPTH];
    logic                 stage_taken       [`PIPE_DEPTH];
    logic                 stage_pred_taken  [`PIPE_DEPTH];
    logic [`PC_WIDTH-1:0] stage_pred_target [`PIPE_DEPTH];

    // valid bits, the only control state here
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            stage_valid <= '0;
        end else if (!stall) begin
            if (flush)
                stage_valid <= '0; // wrong path, incoming fetch dropped too
            else
                stage_valid <= {stage_valid[LAST-1:0], 1'b1}; // fetch enters every cycle
        end
    end

    // payload shifts alongside, meaningless while its valid bit is low
    always_ff @(posedge CLK) begin
        if (!stall) begin
            stage_pc[0]          <= pc_fetch;
            stage_op[0]          <= op_fetch;
            stage_target[0]      <= target_fetch;
            stage_taken[0]       <= taken_fetch;
            stage_pred_taken[0]  <= pred_taken;
            stage_pred_target[0] <= pred_target;
            for (int i = 1; i < `PIPE_DEPTH; i++) begin
                stage_pc[i]          <= stage_pc[i-1];
                stage_op[i]          <= stage_op[i-1];
                stage_target[i]      <= stage_target[i-1];
                stage_taken[i]       <= stage_taken[i-1];
                stage_pred_taken[i]  <= stage_pred_taken[i-1];
                stage_pred_target[i] <= stage_pred_target[i-1];
            end
        end
    end

    assign mem_valid       = stage_valid[LAST];
    assign mem_pc          = stage_pc[LAST];
    assign mem_op          = stage_op[LAST];
    assign mem_target      = stage_target[LAST];
    assign mem_taken       = stage_taken[LAST];
    assign mem_pred_taken  = stage_pred_taken[LAST];
    assign mem_pred_target = stage_pred_target[LAST];

endmodule

// ==== branch_predictor.sv ====
// direction table plus btb, combinational lookup at fetch and training write from memory stage

`include "branch_settings.svh"

module branch_predictor (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic [`PC_WIDTH-1:0] pc_fetch,     // lookup address
    input  logic                 train,        // valid branch resolving this cycle
    input  logic [`PC_WIDTH-1:0] train_pc,     // pc of resolving branch
    input  logic                 dir_wrong,    // predicted direction was wrong
    input  logic [`PC_WIDTH-1:0] train_target, // resolved branch target
    output logic                 pred_taken,
    output logic [`PC_WIDTH-1:0] pred_target   // zero unless pred_taken
);

    import branch_types_pkg::*;

    localparam int IDX_W = `BP_INDEX_HI - 1; // pc[9:2] gives 8 bits

    pred_state_t          state_tab [`BP_ENTRIES];
    logic [`PC_WIDTH-1:0] btb       [`BP_ENTRIES];

    logic [IDX_W-1:0]     fetch_idx;
    logic [IDX_W-1:0]     train_idx;
    pred_state_t          fetch_state;
    logic [`PC_WIDTH-1:0] fetch_btb;
    pred_state_t          train_state;
    pred_state_t          train_state_next;

    assign fetch_idx = pc_fetch[`BP_INDEX_HI:2];
    assign train_idx = train_pc[`BP_INDEX_HI:2];

    // lookup side
    assign fetch_state = state_tab[fetch_idx];
    assign fetch_btb   = btb[fetch_idx];

    always_comb begin
        pred_taken  = 1'b0;
        pred_target = '0;
        // a zero btb entry means no target learned yet
        if ((fetch_state == TAKEN_HARD || fetch_state == TAKEN_SOFT) && fetch_btb != '0) begin
            pred_taken  = 1'b1;
            pred_target = fetch_btb;
        end
    end

    // training side, next state of the entry being trained
    assign train_state = state_tab[train_idx];

    always_comb begin
        train_state_next = train_state;
        if (dir_wrong) begin
            // wrong guess walks one step around the ring
            case (train_state)
                TAKEN_HARD:     train_state_next = TAKEN_SOFT;
                TAKEN_SOFT:     train_state_next = NOT_TAKEN_HARD;
                NOT_TAKEN_HARD: train_state_next = NOT_TAKEN_SOFT;
                NOT_TAKEN_SOFT: train_state_next = TAKEN_HARD;
                default:        train_state_next = TAKEN_HARD;
            endcase
        end else begin
            // correct guess settles into the hard state of the same direction
            case (train_state)
                TAKEN_HARD,
                TAKEN_SOFT:     train_state_next = TAKEN_HARD;
                NOT_TAKEN_HARD,
                NOT_TAKEN_SOFT: train_state_next = NOT_TAKEN_HARD;
                default:        train_state_next = TAKEN_HARD;
            endcase
        end
    end

    // both tables written at the edge ending the train cycle
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                state_tab[i] <= TAKEN_HARD;
                btb[i]       <= '0; // empty btb, nothing predicted taken
            end
        end else if (train) begin
            state_tab[train_idx] <= train_state_next;
            if (btb[train_idx] != train_target) begin
                btb[train_idx] <= train_target; // only rewrite on change
            end
        end
    end

endmodule

// ==== branch_types_pkg.sv ====
// shared enum types for the predictor, the record pipeline and the resolver, imported per module

package branch_types_pkg;

    // 2-bit direction state per table entry
    // taken states come first so bit 1 clear means predict taken
    typedef enum logic [1:0] {
        TAKEN_HARD     = 2'd0, // reset value of every entry
        TAKEN_SOFT     = 2'd1, // one wrong guess away from not taken
        NOT_TAKEN_HARD = 2'd2,
        NOT_TAKEN_SOFT = 2'd3  // one wrong guess away from taken
    } pred_state_t;

    // decoded branch class of a fetched instruction
    // supplied already decoded alongside the fetch pc
    typedef enum logic [1:0] {
        OP_NONE = 2'd0, // not a branch, never trains
        OP_BEQ  = 2'd1, // branch if equal
        OP_BNE  = 2'd2  // branch if not equal
    } branch_op_t;

endpackage

// ==== branch_settings.svh ====
// global sizing macros for the branch prediction front end, included by rtl and testbench

`ifndef BRANCH_SETTINGS_SVH
`define BRANCH_SETTINGS_SVH

// width of every program counter and branch target
`define PC_WIDTH 32

// direction table and btb share one index, one entry per word address
`define BP_ENTRIES 256

// table index is pc[BP_INDEX_HI:2], byte offset bits dropped
`define BP_INDEX_HI 9

// register stages between fetch and the memory stage
`define PIPE_DEPTH 3

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
